// ==== src/game_pkg.sv ====
package game_pkg;

	localparam int MAX_SHOTS = 8; // shot slots
	localparam int MAX_TREES = 16; // tree slots
	localparam int MAX_BIRDS = 4; // bird slots
	localparam int MAX_LEVEL = 7; // last row of the difficulty table

	// difficulty settings of one level
	typedef struct packed {
		logic [2:0] tree_speed;
		logic [1:0] bird_speed;
		logic [1:0] trees_to_add;
		logic [1:0] bird_count; // highest bird index to deploy
		logic [3:0] bird_life;
	} level_cfg_t;

	// one-frame spawn pulses
	typedef struct packed {
		logic [MAX_SHOTS-1:0] shot;
		logic [MAX_TREES-1:0] tree;
		logic [MAX_BIRDS-1:0] bird;
		logic pickup;
	} deploy_t;

	typedef struct packed {
		logic active; // low after game over
		logic red; // hit recovery window
		logic shield;
		logic more_damage;
		logic [1:0] hearts;
	} player_status_t;

	// reload request for the external countdown timer
	typedef struct packed {
		logic valid;
		logic [3:0] tens; // bcd
		logic [3:0] ones; // bcd
	} time_add_t;

	typedef struct packed {
		logic shoot;
		logic god_mode; // cheat, never takes damage
		logic rapid_fire;
	} player_ctrl_t;

endpackage

// ==== src/frame_timer.sv ====
`timescale 1ns/10ps

module frame_timer #(
	parameter int FRAME_CYCLES = 833_333
) (
	input logic clk,
	input logic resetN,
	output logic start_of_frame
);

	localparam int CNT_W = (FRAME_CYCLES > 1) ? $clog2(FRAME_CYCLES) : 1;

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			cnt <= '0;
			start_of_frame <= 1'b0;
		end else begin
			if (cnt == CNT_W'(FRAME_CYCLES - 1)) begin
				cnt <= '0;
				start_of_frame <= 1'b1; // one pulse per wrap
			end else begin
				cnt <= cnt + 1'b1;
				start_of_frame <= 1'b0;
			end
		end
	end

endmodule

// ==== src/frame_hit_latch.sv ====
`timescale 1ns/10ps

module frame_hit_latch (
	input logic clk,
	input logic resetN,
	input logic start_of_frame,
	input logic collision,
	output logic hit
);

	logic pending;

	// the strobe cycle opens a new window, so the old value is dropped
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pending <= 1'b0;
		end else begin
			if (start_of_frame)
				pending <= collision;
			else
				pending <= pending | collision; // hold until next strobe
		end
	end

	// at a strobe this covers the whole previous frame
	assign hit = pending;

endmodule

// ==== src/level_fsm.sv ====
`timescale 1ns/10ps

module level_fsm #(
	parameter int MAX_LEVEL = game_pkg::MAX_LEVEL
) (
	input logic clk,
	input logic resetN,
	input logic level_up,
	output game_pkg::level_cfg_t cfg
);

	localparam int LVL_W = (MAX_LEVEL > 0) ? $clog2(MAX_LEVEL + 1) : 1;

	logic [LVL_W-1:0] level;

	function automatic int min_int(input int a, input int b);
		return (a < b) ? a : b;
	endfunction

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			level <= '0;
		end else begin
			if (level_up && (level != LVL_W'(MAX_LEVEL)))
				level <= level + 1'b1; // stays on the last row
		end
	end

	// difficulty table, each field clipped to its width
	always_comb begin
		cfg.tree_speed = 3'(min_int(int'(level) + 1, 7));
		cfg.bird_speed = 2'(min_int(int'(level) / 2, 3));
		cfg.trees_to_add = 2'(min_int(int'(level) + 1, 3));
		cfg.bird_count = 2'(min_int(int'(level), 3));
		cfg.bird_life = 4'(min_int(int'(level) + 1, 15));
	end

endmodule

// ==== src/game_controller.sv ====
`timescale 1ns/10ps

module game_controller #(
	parameter int COOLDOWN = 100,
	parameter int RAPID_COOLDOWN = 25,
	parameter int TREE_WAIT = 400,
	parameter int RED_FRAMES = 64,
	parameter int LEVEL_PAUSE = 100,
	parameter int POWERUP_FRAMES = 1000
) (
	input logic clk,
	input logic resetN,
	input logic start_of_frame,
	input game_pkg::player_ctrl_t ctrl,
	input logic hit,
	input logic [game_pkg::MAX_BIRDS-1:0] bird_alive,
	input logic pickup_hit,
	input logic out_of_time,
	input logic [7:0] random,
	input game_pkg::level_cfg_t cfg,
	output logic level_up,
	output game_pkg::deploy_t deploy,
	output game_pkg::player_status_t status,
	output game_pkg::time_add_t time_add
);

	localparam int CD_W = $clog2(COOLDOWN + RAPID_COOLDOWN + 1);
	localparam int TW_W = $clog2(TREE_WAIT + 1);
	localparam int RED_W = $clog2(RED_FRAMES + 1);
	localparam int LP_W = $clog2(LEVEL_PAUSE + 1);
	localparam int PU_W = $clog2(POWERUP_FRAMES + 1);
	localparam int SHOT_W = $clog2(game_pkg::MAX_SHOTS);
	localparam int TREE_W = $clog2(game_pkg::MAX_TREES);

	// power-up bits, indexed by random[5:4]
	localparam int PU_SHIELD = 0;
	localparam int PU_RAPID = 1;
	localparam int PU_DAMAGE = 2;
	localparam int PU_LIFE = 3;

	logic [CD_W-1:0] cooldown;
	logic [SHOT_W-1:0] shot_idx;
	logic [TREE_W-1:0] tree_idx;
	logic [TW_W-1:0] tree_cnt;
	logic [7:0] trees_pending;
	logic [7:0] trees_next;
	logic [RED_W-1:0] red_cnt;
	logic [LP_W-1:0] pause_cnt;
	logic [PU_W-1:0] pu_cnt;
	logic [3:0] pu;
	logic start_level;
	logic level_done; // level_up already sent for this level
	logic [game_pkg::MAX_BIRDS-1:0] last_birds;
	logic active;
	logic [1:0] hearts;
	logic [1:0] hearts_next;
	logic invincible;
	logic take_hit;
	logic fire;
	logic tree_due;
	logic bird_killed;

	assign invincible = (red_cnt != '0) || ctrl.god_mode || pu[PU_SHIELD];
	assign take_hit = hit && !invincible;
	assign fire = ctrl.shoot && (cooldown == '0);
	assign tree_due = (trees_pending != '0) && (tree_cnt == TW_W'(TREE_WAIT - 1));
	assign bird_killed = |(last_birds & ~bird_alive); // any bird gone since last frame

	// a tree leaving and a new level arriving in the same frame both count
	always_comb begin
		trees_next = trees_pending;
		if (tree_due)
			trees_next = trees_next - 8'd1;
		if (start_level)
			trees_next = trees_next + 8'(cfg.trees_to_add);
	end

	always_comb begin
		hearts_next = hearts;
		if (take_hit && (hearts > 2'd1))
			hearts_next = hearts - 2'd1;
		if (pu[PU_LIFE] && (hearts_next < 2'd3))
			hearts_next = hearts_next + 2'd1; // life pickup, capped at 3
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			time_add <= '{valid: 1'b1, tens: 4'd9, ones: 4'd9}; // timer starts at 99
			level_up <= 1'b0;
			deploy <= '0;
			cooldown <= '0;
			shot_idx <= '0;
			tree_idx <= '0;
			tree_cnt <= '0;
			trees_pending <= '0;
			red_cnt <= '0;
			pause_cnt <= '0;
			pu_cnt <= '0;
			pu <= '0;
			start_level <= 1'b1;
			level_done <= 1'b0;
			last_birds <= '0;
			active <= 1'b1;
			hearts <= 2'd3;
		end else begin
			time_add <= '0;
			level_up <= 1'b0;
			if (start_of_frame) begin
				deploy <= '0; // pulses last one frame
				cooldown <= (cooldown != '0) ? cooldown - 1'b1 : '0;
				tree_cnt <= (tree_cnt == TW_W'(TREE_WAIT)) ? '0 : tree_cnt + 1'b1;
				red_cnt <= (red_cnt != '0) ? red_cnt - 1'b1 : '0;
				pause_cnt <= (pause_cnt != '0) ? pause_cnt - 1'b1 : '0;
				pu_cnt <= (pu_cnt != '0) ? pu_cnt - 1'b1 : '0;
				start_level <= 1'b0;
				trees_pending <= trees_next;
				hearts <= hearts_next;
				last_birds <= bird_alive;

				if (fire) begin
					deploy.shot[shot_idx] <= 1'b1;
					if (shot_idx == SHOT_W'(game_pkg::MAX_SHOTS - 1))
						shot_idx <= '0;
					else
						shot_idx <= shot_idx + 1'b1;
					if (ctrl.rapid_fire || pu[PU_RAPID])
						cooldown <= CD_W'(RAPID_COOLDOWN);
					else
						cooldown <= CD_W'(COOLDOWN);
				end

				if (tree_due) begin
					deploy.tree[tree_idx] <= 1'b1;
					if (tree_idx == TREE_W'(game_pkg::MAX_TREES - 1))
						tree_idx <= '0;
					else
						tree_idx <= tree_idx + 1'b1;
				end

				if (start_level) begin
					for (int i = 0; i < game_pkg::MAX_BIRDS; i++) begin
						if (i <= int'(cfg.bird_count))
							deploy.bird[i] <= 1'b1;
					end
					deploy.pickup <= 1'b1;
				end

				if (take_hit) begin
					if (hearts > 2'd1)
						red_cnt <= RED_W'(RED_FRAMES);
					else
						active <= 1'b0; // last heart lost
				end

				if (out_of_time)
					active <= 1'b0;

				if (bird_alive != '0) begin
					level_done <= 1'b0;
				end else if (!level_done) begin
					pause_cnt <= LP_W'(LEVEL_PAUSE);
					level_up <= 1'b1;
					level_done <= 1'b1;
				end

				// next level only if no birds came back during the pause
				if ((pause_cnt == LP_W'(1)) && (bird_alive == '0))
					start_level <= 1'b1;

				if (bird_killed && active)
					time_add <= '{valid: 1'b1, tens: 4'd1, ones: 4'd0};

				if (pu_cnt == '0)
					pu <= '0;
				if (pickup_hit) begin
					pu[random[5:4]] <= 1'b1;
					pu_cnt <= PU_W'(POWERUP_FRAMES);
				end
				if (pu[PU_LIFE])
					pu[PU_LIFE] <= 1'b0; // applied once through hearts_next
			end
		end
	end

	assign status = '{
		active: active,
		red: (red_cnt != '0),
		shield: ctrl.god_mode | pu[PU_SHIELD],
		more_damage: pu[PU_DAMAGE],
		hearts: hearts
	};

endmodule

// ==== src/game_core.sv ====
`timescale 1ns/10ps

module game_core #(
	parameter int FRAME_CYCLES = 833_333, // 25 MHz clock, 30 frames per second
	parameter int MAX_LEVEL = game_pkg::MAX_LEVEL,
	parameter int COOLDOWN = 100,
	parameter int RAPID_COOLDOWN = 25,
	parameter int TREE_WAIT = 400,
	parameter int RED_FRAMES = 64,
	parameter int LEVEL_PAUSE = 100,
	parameter int POWERUP_FRAMES = 1000
) (
	input logic clk,
	input logic resetN,
	input game_pkg::player_ctrl_t ctrl,
	input logic collision,
	input logic [game_pkg::MAX_BIRDS-1:0] bird_alive,
	input logic pickup_hit,
	input logic out_of_time,
	input logic [7:0] random,
	output logic start_of_frame,
	output game_pkg::level_cfg_t level,
	output game_pkg::deploy_t deploy,
	output game_pkg::player_status_t status,
	output game_pkg::time_add_t time_add
);

	logic hit;
	logic level_up;

	frame_timer #(
		.FRAME_CYCLES(FRAME_CYCLES)
	) i_frame_timer (
		.clk(clk),
		.resetN(resetN),
		.start_of_frame(start_of_frame)
	);

	frame_hit_latch i_hit_latch (
		.clk(clk),
		.resetN(resetN),
		.start_of_frame(start_of_frame),
		.collision(collision),
		.hit(hit)
	);

	level_fsm #(
		.MAX_LEVEL(MAX_LEVEL)
	) i_level_fsm (
		.clk(clk),
		.resetN(resetN),
		.level_up(level_up),
		.cfg(level)
	);

	game_controller #(
		.COOLDOWN(COOLDOWN),
		.RAPID_COOLDOWN(RAPID_COOLDOWN),
		.TREE_WAIT(TREE_WAIT),
		.RED_FRAMES(RED_FRAMES),
		.LEVEL_PAUSE(LEVEL_PAUSE),
		.POWERUP_FRAMES(POWERUP_FRAMES)
	) i_controller (
		.clk(clk),
		.resetN(resetN),
		.start_of_frame(start_of_frame),
		.ctrl(ctrl),
		.hit(hit),
		.bird_alive(bird_alive),
		.pickup_hit(pickup_hit),
		.out_of_time(out_of_time),
		.random(random),
		.cfg(level),
		.level_up(level_up),
		.deploy(deploy),
		.status(status),
		.time_add(time_add)
	);

endmodule

// ==== test/game_core_assertions.sv ====
`timescale 1ns/10ps

module game_core_assertions (
	input logic clk,
	input logic resetN,
	input logic start_of_frame,
	input logic level_up,
	input game_pkg::deploy_t deploy,
	input game_pkg::player_status_t status
);

	int fail_count = 0; // summed into the testbench result

	strobe_one_cycle: assert property (@(posedge clk) disable iff (!resetN)
		start_of_frame |=> !start_of_frame)
		else begin
			$error("start_of_frame high for more than one cycle");
			fail_count++;
		end

	level_up_one_cycle: assert property (@(posedge clk) disable iff (!resetN)
		level_up |=> !level_up)
		else begin
			$error("level_up high for more than one cycle");
			fail_count++;
		end

	// spawn pulses only move on a frame edge
	deploy_after_strobe: assert property (@(posedge clk) disable iff (!resetN)
		$changed(deploy) |-> $past(start_of_frame))
		else begin
			$error("deploy changed outside the cycle after a strobe");
			fail_count++;
		end

	// a heart added past 3 would wrap to 0
	hearts_in_range: assert property (@(posedge clk) disable iff (!resetN)
		!$isunknown(status.hearts) && (status.hearts != 2'd0))
		else begin
			$error("hearts unknown or wrapped past 3");
			fail_count++;
		end

endmodule

bind game_core game_core_assertions i_assertions (
	.clk(clk),
	.resetN(resetN),
	.start_of_frame(start_of_frame),
	.level_up(level_up),
	.deploy(deploy),
	.status(status)
);

// ==== test/game_core_tb.sv ====
`timescale 1ns/10ps

module game_core_tb;

	localparam int FRAME_CYCLES = 8;
	localparam int COOLDOWN = 3;
	localparam int RAPID_COOLDOWN = 1;
	localparam int TREE_WAIT = 6;
	localparam int RED_FRAMES = 4;
	localparam int LEVEL_PAUSE = 5;
	localparam int POWERUP_FRAMES = 10;
	localparam int CLK_NS = 4;
	localparam int SHOT_FRAMES = 24;
	localparam int LEVEL_ROUNDS = 3;
	localparam int BONUS_FRAMES = 20;
	localparam int DAMAGE_FRAMES = 30;
	localparam int TEST_FRAMES = SHOT_FRAMES + LEVEL_ROUNDS * (LEVEL_PAUSE + 10) + BONUS_FRAMES
		+ 4 * (POWERUP_FRAMES + 3) + DAMAGE_FRAMES;
	localparam int TIMEOUT_NS = (TEST_FRAMES + 4) * FRAME_CYCLES * CLK_NS + 200;

	logic clk = 1'b0;
	logic resetN;
	game_pkg::player_ctrl_t ctrl;
	logic collision;
	logic [3:0] bird_alive;
	logic pickup_hit;
	logic out_of_time;
	logic [7:0] random;
	logic start_of_frame;
	game_pkg::level_cfg_t level;
	game_pkg::deploy_t deploy;
	game_pkg::player_status_t status;
	game_pkg::time_add_t time_add;

	// frame-level reference model
	int m_cooldown, m_shot_idx, m_tree_idx, m_tree_cnt, m_trees;
	int m_red_cnt, m_pause, m_pu_cnt, m_hearts, m_level;
	logic [3:0] m_pu;
	logic [3:0] m_last_birds;
	logic m_start, m_level_done, m_active, m_level_up;
	game_pkg::deploy_t m_deploy;
	game_pkg::time_add_t m_time;

	logic hit_acc; // collision seen since the last strobe
	logic cmp_due;
	logic saw_strobe;
	int since_strobe, coll_pct, errors, err_mark, test_num;

	game_core #(
		.FRAME_CYCLES(FRAME_CYCLES),
		.COOLDOWN(COOLDOWN),
		.RAPID_COOLDOWN(RAPID_COOLDOWN),
		.TREE_WAIT(TREE_WAIT),
		.RED_FRAMES(RED_FRAMES),
		.LEVEL_PAUSE(LEVEL_PAUSE),
		.POWERUP_FRAMES(POWERUP_FRAMES)
	) i_dut (
		.clk(clk),
		.resetN(resetN),
		.ctrl(ctrl),
		.collision(collision),
		.bird_alive(bird_alive),
		.pickup_hit(pickup_hit),
		.out_of_time(out_of_time),
		.random(random),
		.start_of_frame(start_of_frame),
		.level(level),
		.deploy(deploy),
		.status(status),
		.time_add(time_add)
	);

	always #(CLK_NS / 2) clk = ~clk;

	task automatic check_deploy(input game_pkg::deploy_t exp);
		if (deploy !== exp) begin
			$display("Fail %0t deploy expected %h got %h", $time, exp, deploy);
			errors++;
		end
	endtask

	task automatic check_status(input game_pkg::player_status_t exp);
		if (status !== exp) begin
			$display("Fail %0t status expected %b got %b", $time, exp, status);
			errors++;
		end
	endtask

	task automatic check_level(input game_pkg::level_cfg_t exp);
		if (level !== exp) begin
			$display("Fail %0t level expected %h got %h", $time, exp, level);
			errors++;
		end
	endtask

	task automatic check_time(input game_pkg::time_add_t exp);
		if (time_add !== exp) begin
			$display("Fail %0t time_add expected %h got %h", $time, exp, time_add);
			errors++;
		end
	endtask

	// difficulty row for level l
	function automatic game_pkg::level_cfg_t level_row(input int l);
		game_pkg::level_cfg_t row;
		row.tree_speed = 3'((l + 1 > 7) ? 7 : l + 1);
		row.bird_speed = 2'((l / 2 > 3) ? 3 : l / 2);
		row.trees_to_add = 2'((l + 1 > 3) ? 3 : l + 1);
		row.bird_count = 2'((l > 3) ? 3 : l);
		row.bird_life = 4'((l + 1 > 15) ? 15 : l + 1);
		return row;
	endfunction

	function automatic game_pkg::player_status_t model_status();
		game_pkg::player_status_t s;
		s.active = m_active;
		s.red = (m_red_cnt > 0);
		s.shield = ctrl.god_mode | m_pu[0]; // follows the button directly
		s.more_damage = m_pu[2];
		s.hearts = 2'(m_hearts);
		return s;
	endfunction

	function automatic game_pkg::player_ctrl_t random_buttons(input int god_pct);
		game_pkg::player_ctrl_t b;
		b.shoot = ($urandom % 4) != 0;
		b.rapid_fire = ($urandom % 3) == 0;
		b.god_mode = ($urandom % 100) < god_pct;
		return b;
	endfunction

	// one strobe worth of game rules, using the inputs held during the strobe cycle
	task automatic model_frame(input logic hit);
		game_pkg::level_cfg_t cfg;
		logic take_hit;
		logic fire;
		logic tree_due;
		logic [3:0] pu_old;
		cfg = level_row(m_level);
		take_hit = hit && !(m_red_cnt > 0 || ctrl.god_mode || m_pu[0]);
		fire = ctrl.shoot && (m_cooldown == 0);
		tree_due = (m_trees > 0) && (m_tree_cnt == TREE_WAIT - 1);
		pu_old = m_pu;
		m_deploy = '0;
		m_time = '0;
		m_level_up = 1'b0;
		if (|(m_last_birds & ~bird_alive) && m_active)
			m_time = '{valid: 1'b1, tens: 4'd1, ones: 4'd0}; // ten seconds
		m_last_birds = bird_alive;
		m_cooldown = (m_cooldown > 0) ? m_cooldown - 1 : 0;
		if (fire) begin
			m_deploy.shot[m_shot_idx] = 1'b1;
			m_shot_idx = (m_shot_idx + 1) % game_pkg::MAX_SHOTS;
			m_cooldown = (ctrl.rapid_fire || pu_old[1]) ? RAPID_COOLDOWN : COOLDOWN;
		end
		if (tree_due) begin
			m_deploy.tree[m_tree_idx] = 1'b1;
			m_tree_idx = (m_tree_idx + 1) % game_pkg::MAX_TREES;
			m_trees--;
		end
		m_tree_cnt = (m_tree_cnt == TREE_WAIT) ? 0 : m_tree_cnt + 1;
		if (m_start) begin
			for (int i = 0; i <= int'(cfg.bird_count); i++)
				m_deploy.bird[i] = 1'b1;
			m_deploy.pickup = 1'b1;
			m_trees += cfg.trees_to_add;
		end
		m_start = (m_pause == 1) && (bird_alive == '0);
		m_pause = (m_pause > 0) ? m_pause - 1 : 0;
		if (bird_alive != '0) begin
			m_level_done = 1'b0;
		end else if (!m_level_done) begin
			m_pause = LEVEL_PAUSE;
			m_level_up = 1'b1;
			m_level_done = 1'b1;
		end
		m_red_cnt = (m_red_cnt > 0) ? m_red_cnt - 1 : 0;
		if (take_hit) begin
			if (m_hearts > 1) begin
				m_hearts--;
				m_red_cnt = RED_FRAMES;
			end else begin
				m_active = 1'b0;
			end
		end
		if (out_of_time)
			m_active = 1'b0;
		if (pu_old[3] && m_hearts < 3)
			m_hearts++;
		if (m_pu_cnt == 0)
			m_pu = '0;
		m_pu_cnt = (m_pu_cnt > 0) ? m_pu_cnt - 1 : 0;
		if (pickup_hit) begin
			m_pu[random[5:4]] = 1'b1;
			m_pu_cnt = POWERUP_FRAMES;
		end
		if (pu_old[3])
			m_pu[3] = 1'b0; // life is used up at once
	endtask

	// called at each falling edge, where all outputs are settled
	task automatic observe();
		since_strobe++;
		if (cmp_due) begin
			check_deploy(m_deploy);
			check_status(model_status());
			check_time(m_time);
			if (m_level_up && m_level < game_pkg::MAX_LEVEL)
				m_level++;
			cmp_due = 1'b0;
		end else begin
			check_time('0);
		end
		saw_strobe = start_of_frame;
		if (start_of_frame) begin
			if (since_strobe != FRAME_CYCLES) begin
				$display("frame strobe came %0d cycles after the last one at %0t",
					since_strobe, $time);
				errors++;
			end
			since_strobe = 0;
			check_level(level_row(m_level));
			model_frame(hit_acc);
			hit_acc = collision;
			cmp_due = 1'b1;
		end else begin
			hit_acc = hit_acc | collision;
		end
	endtask

	task automatic cycle_rest();
		collision = ($urandom % 100) < coll_pct;
		@(negedge clk);
		observe();
	endtask

	task automatic tick();
		@(posedge clk);
		#1;
		cycle_rest();
	endtask

	// new frame inputs right after a strobe, then run up to the next strobe
	task automatic frame(input game_pkg::player_ctrl_t c, input logic [3:0] birds,
		input logic pickup, input logic timeout, input logic [7:0] rnd);
		saw_strobe = 1'b0;
		@(posedge clk);
		#1;
		ctrl = c;
		bird_alive = birds;
		pickup_hit = pickup;
		out_of_time = timeout;
		random = rnd;
		cycle_rest();
		while (!saw_strobe)
			tick();
	endtask

	task automatic end_test(input string name);
		$display("test %0d %s: %0d errors", test_num, name, errors - err_mark);
		test_num++;
		err_mark = errors;
	endtask

	initial begin
		logic [3:0] birds;
		void'($urandom(32'h0fad_8323));
		resetN = 1'b0;
		ctrl = '0;
		collision = 1'b0;
		bird_alive = 4'hf;
		pickup_hit = 1'b0;
		out_of_time = 1'b0;
		random = '0;
		{m_cooldown, m_shot_idx, m_tree_idx, m_tree_cnt, m_trees} = '0;
		{m_red_cnt, m_pause, m_pu_cnt, m_level} = '0;
		m_hearts = 3;
		m_pu = '0;
		m_last_birds = '0;
		m_start = 1'b1;
		m_level_done = 1'b0;
		m_active = 1'b1;
		m_level_up = 1'b0;
		{hit_acc, cmp_due, saw_strobe} = '0;
		{since_strobe, coll_pct, errors, err_mark} = '0;
		test_num = 1;

		repeat (4) @(posedge clk);
		@(negedge clk);
		check_time('{valid: 1'b1, tens: 4'd9, ones: 4'd9});
		check_status(model_status());
		check_deploy('0);
		if (start_of_frame !== 1'b0) begin
			$display("start_of_frame is not low during reset at %0t", $time);
			errors++;
		end
		@(posedge clk);
		#1;
		resetN = 1'b1;
		while (!saw_strobe)
			tick();
		end_test("reset and frame timing");

		repeat (SHOT_FRAMES)
			frame(random_buttons(0), 4'hf, 1'b0, 1'b0, 8'($urandom));
		end_test("shots");

		for (int r = 0; r < LEVEL_ROUNDS; r++) begin
			repeat (8)
				frame(random_buttons(0), 4'hf, 1'b0, 1'b0, 8'($urandom));
			repeat (LEVEL_PAUSE + 2)
				frame(random_buttons(0), 4'h0, 1'b0, 1'b0, 8'($urandom));
		end
		end_test("level flow");

		birds = 4'hf;
		repeat (BONUS_FRAMES) begin
			birds = (($urandom % 4) == 0) ? 4'hf : birds & 4'($urandom);
			if (birds == '0)
				birds = 4'h1; // keep the level running
			frame(random_buttons(0), birds, 1'b0, 1'b0, 8'($urandom));
		end
		end_test("time bonus");

		// full hearts here, so red, god_mode and the last heart are all visible
		coll_pct = 10;
		for (int f = 0; f < DAMAGE_FRAMES; f++)
			frame(random_buttons(20), birds, 1'b0, f >= DAMAGE_FRAMES - 2, 8'($urandom));
		end_test("damage and game over");

		coll_pct = 3;
		for (int sel = 0; sel < 4; sel++) begin
			frame(random_buttons(0), birds, 1'b1, 1'b0, {2'($urandom), 2'(sel), 4'($urandom)});
			repeat (POWERUP_FRAMES + 2)
				frame(random_buttons(0), birds, 1'b0, 1'b0, 8'($urandom));
		end
		end_test("power-ups");

		errors = errors + i_dut.i_assertions.fail_count;
		$display("tests %0d, errors %0d, assertion failures %0d", test_num - 1, errors,
			i_dut.i_assertions.fail_count);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout, the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== sim.f ====
src/game_pkg.sv
src/frame_timer.sv
src/frame_hit_latch.sv
src/level_fsm.sv
src/game_controller.sv
src/game_core.sv
test/game_core_assertions.sv
test/game_core_tb.sv

// ==== Bender.yml ====
package:
  name: game_core

sources:
  - src/game_pkg.sv
  - src/frame_timer.sv
  - src/frame_hit_latch.sv
  - src/level_fsm.sv
  - src/game_controller.sv
  - src/game_core.sv
  - target: test
    files:
      - test/game_core_assertions.sv
      - test/game_core_tb.sv
